/* run.sh */
#!/bin/sh
# build the DDC FIR testbench with Verilator, run it, and judge the run from its log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module ddcFirTb \
   -o ddcFirSim > build.log 2>&1 &&
   ./obj_dir/ddcFirSim > sim.log 2>&1
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

/* sim.f */
+incdir+src
src/ddcFirPkg.sv
src/firCoeffIf.sv
src/firCoeffRegs.sv
src/symFirFilter.sv
src/ddcFirTop.sv
test/ddcFirTb.sv

/* src/ddcFirPkg.sv */
// DDC FIR shared types for coefficient words and the coefficient set
`include "ddcFir_config.svh"

package ddcFirPkg;

   // one APB coefficient word
   // pair view splits it into the two packed coefficients,
   // lane view into the byte lanes addressed by pstrb
   typedef union packed {
      struct packed {
         logic signed [`DDC_FIR_COEFF_W-1:0] hi;
         logic signed [`DDC_FIR_COEFF_W-1:0] lo;
      } pair;
      logic [`DDC_FIR_APB_DATA_W/8-1:0][7:0] lane;
   } coeffWord_t;

   // distinct coefficients c0..c7, c7 is the centre tap
   typedef logic signed [`DDC_FIR_COEFF_W-1:0] coeffArray_t [`DDC_FIR_NUM_COEFF];

endpackage

/* src/ddcFirTop.sv */
// DDC FIR stage top, APB coefficient registers feeding the symmetric filter
`timescale 1ns/1ps
`include "ddcFir_config.svh"

module ddcFirTop (
   input  logic                              clk,
   input  logic                              rst,
   // APB slave
   input  logic [`DDC_FIR_APB_ADDR_W-1:0]    paddr,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [`DDC_FIR_APB_DATA_W-1:0]    pwdata,
   input  logic [`DDC_FIR_APB_DATA_W/8-1:0]  pstrb,
   output logic [`DDC_FIR_APB_DATA_W-1:0]    prdata,
   output logic                              pready,
   output logic                              pslverr,
   // sample stream
   input  logic [`DDC_FIR_SAMPLE_W-1:0]      sampleIn,
   input  logic                              sampleValid,
   output logic [`DDC_FIR_SAMPLE_W-1:0]      sampleOut,
   output logic                              outValid
);

   firCoeffIf coefBus ();

   firCoeffRegs firCoeffRegs_i (
      .clk     (clk),
      .rst     (rst),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .pstrb   (pstrb),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .coef    (coefBus.regs)
   );

   symFirFilter symFirFilter_i (
      .clk         (clk),
      .rst         (rst),
      .sampleIn    (sampleIn),
      .sampleValid (sampleValid),
      .sampleOut   (sampleOut),
      .outValid    (outValid),
      .coef        (coefBus.filter)
   );

endmodule

/* src/ddcFir_config.svh */
// DDC FIR stage sizes, APB register map and pipeline depth
`ifndef DDC_FIR_CONFIG_SVH
`define DDC_FIR_CONFIG_SVH

// filter geometry, 15 taps folded onto 8 distinct coefficients
`define DDC_FIR_NUM_TAPS    15
`define DDC_FIR_NUM_COEFF   8

// signed Q1.15 coefficients and 16-bit samples
`define DDC_FIR_COEFF_W     16
`define DDC_FIR_SAMPLE_W    16
`define DDC_FIR_FRAC_BITS   15
`define DDC_FIR_ACC_W       36

// sample in to outValid, in clock cycles
`define DDC_FIR_LATENCY     3

// APB port
`define DDC_FIR_APB_ADDR_W  8
`define DDC_FIR_APB_DATA_W  32
`define DDC_FIR_NUM_WORDS   4

// word k holds coeff 2k in [15:0] and coeff 2k+1 in [31:16]
`define DDC_FIR_COEFF_0     8'h00
`define DDC_FIR_COEFF_1     8'h04
`define DDC_FIR_COEFF_2     8'h08
`define DDC_FIR_COEFF_3     8'h0C
// bit 0 enables the filter
`define DDC_FIR_CTRL        8'h10

`endif

/* src/firCoeffIf.sv */
// FIR coefficient bus from the register file to the filter datapath
`timescale 1ns/1ps

interface firCoeffIf;
   import ddcFirPkg::*;

   // current coefficient set, c0 first
   coeffArray_t coeffs;
   // filter runs only while set
   logic        firEnable;
   // one cycle, follows any accepted coefficient write
   logic        coeffWrite;

   modport regs (
      output coeffs,
      output firEnable,
      output coeffWrite
   );

   modport filter (
      input coeffs,
      input firEnable,
      input coeffWrite
   );

endinterface

/* src/firCoeffRegs.sv */
// APB register file holding the FIR coefficients and the filter enable
`timescale 1ns/1ps
`include "ddcFir_config.svh"

module firCoeffRegs (
   input  logic                              clk,
   input  logic                              rst,
   input  logic [`DDC_FIR_APB_ADDR_W-1:0]    paddr,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [`DDC_FIR_APB_DATA_W-1:0]    pwdata,
   input  logic [`DDC_FIR_APB_DATA_W/8-1:0]  pstrb,
   output logic [`DDC_FIR_APB_DATA_W-1:0]    prdata,
   output logic                              pready,
   output logic                              pslverr,
   firCoeffIf.regs                           coef
);
   import ddcFirPkg::*;

   localparam int NumWords = `DDC_FIR_NUM_WORDS;
   localparam int NumLanes = `DDC_FIR_APB_DATA_W / 8;

   coeffWord_t          coeffReg [NumWords];
   coeffWord_t          wrWord;
   logic                ctrlEnable;
   logic                coeffWritePulse;
   logic [NumWords-1:0] wordSel;
   logic                ctrlSel;
   logic                mapped;
   logic                setup;
   logic                access;
   logic                wrAccess;

   // write data seen byte by byte
   assign wrWord = pwdata;

   assign setup    = psel & ~penable;
   assign access   = psel & penable & pready;
   assign wrAccess = access & pwrite & mapped;

   // address decode
   always_comb begin
      wordSel = '0;
      ctrlSel = 1'b0;
      case (paddr)
         `DDC_FIR_COEFF_0: wordSel[0] = 1'b1;
         `DDC_FIR_COEFF_1: wordSel[1] = 1'b1;
         `DDC_FIR_COEFF_2: wordSel[2] = 1'b1;
         `DDC_FIR_COEFF_3: wordSel[3] = 1'b1;
         `DDC_FIR_CTRL:    ctrlSel    = 1'b1;
         default: ;
      endcase
      mapped = (|wordSel) | ctrlSel;
   end

   // no wait states
   // ready and error are set from the setup cycle, paddr is stable across the transfer
   always_ff @(posedge clk) begin
      if (rst) begin
         pready  <= 1'b0;
         pslverr <= 1'b0;
      end else begin
         pready  <= setup;
         pslverr <= setup & ~mapped;
      end
   end

   // strobed byte merge into the coefficient words
   always_ff @(posedge clk) begin
      if (rst) begin
         for (int w = 0; w < NumWords; w++) begin
            coeffReg[w] <= '0;
         end
         ctrlEnable      <= 1'b0;
         coeffWritePulse <= 1'b0;
      end else begin
         coeffWritePulse <= wrAccess & (|wordSel);
         for (int w = 0; w < NumWords; w++) begin
            if (wrAccess && wordSel[w]) begin
               for (int b = 0; b < NumLanes; b++) begin
                  if (pstrb[b]) begin
                     coeffReg[w].lane[b] <= wrWord.lane[b];
                  end
               end
            end
         end
         // enable lives in lane 0
         if (wrAccess && ctrlSel && pstrb[0]) begin
            ctrlEnable <= pwdata[0];
         end
      end
   end

   // read mux, zero for unmapped addresses
   always_comb begin
      prdata = '0;
      for (int w = 0; w < NumWords; w++) begin
         if (wordSel[w]) begin
            prdata = {coeffReg[w].pair.hi, coeffReg[w].pair.lo};
         end
      end
      if (ctrlSel) begin
         prdata[0] = ctrlEnable;
      end
   end

   // even coefficient from the low half, odd from the high half
   for (genvar w = 0; w < NumWords; w++) begin : gCoeffOut
      assign coef.coeffs[2*w]   = coeffReg[w].pair.lo;
      assign coef.coeffs[2*w+1] = coeffReg[w].pair.hi;
   end

   assign coef.firEnable  = ctrlEnable;
   assign coef.coeffWrite = coeffWritePulse;

   // ready only ever answers an access cycle
   assert property (@(posedge clk) disable iff (rst)
      pready |-> (psel && penable))
      else $error("pready outside an APB access cycle");

   // error is a completed transfer to an address still unmapped
   assert property (@(posedge clk) disable iff (rst)
      pslverr |-> (pready && !mapped))
      else $error("pslverr without pready or for a mapped address");

endmodule

/* src/symFirFilter.sv */
// Pipelined 15-tap symmetric FIR with pre-adders and saturating output
`timescale 1ns/1ps
`include "ddcFir_config.svh"

module symFirFilter (
   input  logic                                clk,
   input  logic                                rst,
   input  logic signed [`DDC_FIR_SAMPLE_W-1:0] sampleIn,
   input  logic                                sampleValid,
   output logic signed [`DDC_FIR_SAMPLE_W-1:0] sampleOut,
   output logic                                outValid,
   firCoeffIf.filter                           coef
);
   import ddcFirPkg::*;

   localparam int SampleW  = `DDC_FIR_SAMPLE_W;
   localparam int PreW     = SampleW + 1;
   localparam int ProdW    = PreW + `DDC_FIR_COEFF_W;
   localparam int AccW     = `DDC_FIR_ACC_W;
   localparam int FracBits = `DDC_FIR_FRAC_BITS;
   localparam int ScaledW  = AccW - FracBits;
   localparam int NumTaps  = `DDC_FIR_NUM_TAPS;
   localparam int NumCoeff = `DDC_FIR_NUM_COEFF;
   localparam int Centre   = NumCoeff - 1;

   logic                      accept;
   // delay line, entry 0 is the sample arriving this cycle
   logic signed [SampleW-1:0] window [NumTaps];
   logic signed [SampleW-1:0] history [NumTaps-1];
   logic signed [PreW-1:0]    preSum [NumCoeff];
   coeffArray_t               coeffHold;
   logic signed [ProdW-1:0]   product [NumCoeff];
   logic signed [AccW-1:0]    accSum;
   logic signed [ScaledW-1:0] scaled;
   logic signed [SampleW-1:0] satOut;
   logic                      preValid;
   logic                      prodValid;

   // disabled samples are dropped before the delay line
   assign accept = sampleValid & coef.firEnable;

   always_comb begin
      window[0] = sampleIn;
      for (int i = 1; i < NumTaps; i++) begin
         window[i] = history[i-1];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NumTaps - 1; i++) begin
            history[i] <= '0;
         end
      end else if (accept) begin
         for (int i = 0; i < NumTaps - 1; i++) begin
            history[i] <= window[i];
         end
      end
   end

   // valid bit alongside each stage
   always_ff @(posedge clk) begin
      if (rst) begin
         preValid  <= 1'b0;
         prodValid <= 1'b0;
         outValid  <= 1'b0;
      end else begin
         preValid  <= accept;
         prodValid <= preValid;
         outValid  <= prodValid;
      end
   end

   // stage 1: fold tap k with tap 14-k
   // coefficients are captured with the sample, so each one sees a single set
   always_ff @(posedge clk) begin
      if (accept) begin
         for (int k = 0; k < Centre; k++) begin
            preSum[k] <= PreW'(window[k]) + PreW'(window[NumTaps-1-k]);
         end
         preSum[Centre] <= PreW'(window[Centre]);
         coeffHold      <= coef.coeffs;
      end
   end

   // stage 2: one multiplier per distinct coefficient
   always_ff @(posedge clk) begin
      if (preValid) begin
         for (int k = 0; k < NumCoeff; k++) begin
            product[k] <= preSum[k] * coeffHold[k];
         end
      end
   end

   // stage 3: adder tree, drop fraction bits, clip to 16 bits
   always_comb begin
      accSum = '0;
      for (int k = 0; k < NumCoeff; k++) begin
         accSum = accSum + AccW'(product[k]);
      end
      // dropping low bits of two's complement rounds toward minus infinity
      scaled = accSum[AccW-1:FracBits];
      if ((&scaled[ScaledW-1:SampleW-1]) || ~(|scaled[ScaledW-1:SampleW-1])) begin
         satOut = scaled[SampleW-1:0];
      end else if (scaled[ScaledW-1]) begin
         satOut = {1'b1, {(SampleW-1){1'b0}}};
      end else begin
         satOut = {1'b0, {(SampleW-1){1'b1}}};
      end
   end

   always_ff @(posedge clk) begin
      if (prodValid) begin
         sampleOut <= satOut;
      end
   end

   // one output per accepted sample, fixed delay, nothing extra
   assert property (@(posedge clk) disable iff (rst)
      outValid == $past(accept, `DDC_FIR_LATENCY))
      else $error("outValid not aligned with accepted samples");

   assert property (@(posedge clk) disable iff (rst)
      outValid |-> !$isunknown(sampleOut))
      else $error("unknown sampleOut while outValid");

   // coefficients only move right after a register write
   for (genvar k = 0; k < NumCoeff; k++) begin : gCoeffStable
      assert property (@(posedge clk) disable iff (rst)
         $changed(coef.coeffs[k]) |-> coef.coeffWrite)
         else $error("coefficient %0d changed without a write pulse", k);
   end

endmodule

/* test/ddcFirTb.sv */
// DDC FIR stage testbench with APB programming, sample stimulus and a reference model
`timescale 1ns/1ps
`include "ddcFir_config.svh"

module ddcFirTb;

   // the tests take about 650 cycles, so this limit leaves plenty of margin
   localparam int MaxCycles = 2000;
   localparam int NumTaps   = `DDC_FIR_NUM_TAPS;
   localparam int Latency   = `DDC_FIR_LATENCY;

   logic        clk;
   logic        rst;
   logic [7:0]  paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [31:0] pwdata;
   logic [3:0]  pstrb;
   logic [31:0] prdata;
   logic        pready;
   logic        pslverr;
   logic [15:0] sampleIn;
   logic        sampleValid;
   logic [15:0] sampleOut;
   logic        outValid;

   // shadow of the register file and of the filter delay line
   logic [31:0] shadowWord [4];
   logic        shadowEnable;
   longint      hist [NumTaps];
   // expected outputs and the cycle each one is due
   logic [15:0] expQ [$];
   int          dueQ [$];

   int          cycles;
   int          errors;
   int          testsRun;
   int          testsFailed;
   int          testErrStart;
   int          clipHi;
   int          clipLo;
   integer      seed;
   string       testName;

   ddcFirTop ddcFirTop_i (
      .clk         (clk),
      .rst         (rst),
      .paddr       (paddr),
      .psel        (psel),
      .penable     (penable),
      .pwrite      (pwrite),
      .pwdata      (pwdata),
      .pstrb       (pstrb),
      .prdata      (prdata),
      .pready      (pready),
      .pslverr     (pslverr),
      .sampleIn    (sampleIn),
      .sampleValid (sampleValid),
      .sampleOut   (sampleOut),
      .outValid    (outValid)
   );

   always #10 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= MaxCycles) begin
         $display("timeout, run stopped after %0d cycles", cycles);
         $display("tests failed");
         $finish;
      end
   end

   // output checker, every output must match the oldest pending sample
   always @(negedge clk) begin
      if (!rst) begin
         if (outValid) begin
            assert (expQ.size() > 0)
               else begin
                  errors++;
                  $display("%s: outValid with no accepted sample in flight", testName);
               end
            if (expQ.size() > 0) begin
               assert (dueQ[0] == cycles)
                  else begin
                     errors++;
                     $display("Mismatch %s latency: expected cycle %0d, actual cycle %0d",
                              testName, dueQ[0], cycles);
                  end
               assert (sampleOut == expQ[0])
                  else begin
                     errors++;
                     $display("Mismatch %s: expected %h, actual %h",
                              testName, expQ[0], sampleOut);
                  end
               void'(expQ.pop_front());
               void'(dueQ.pop_front());
            end
         end else if (dueQ.size() > 0) begin
            assert (dueQ[0] > cycles)
               else begin
                  errors++;
                  $display("%s: no outValid for the sample due at cycle %0d",
                           testName, dueQ[0]);
                  void'(expQ.pop_front());
                  void'(dueQ.pop_front());
               end
         end
      end
   end

   function automatic logic [7:0] regAddr(input int i);
      case (i)
         0: return `DDC_FIR_COEFF_0;
         1: return `DDC_FIR_COEFF_1;
         2: return `DDC_FIR_COEFF_2;
         3: return `DDC_FIR_COEFF_3;
         default: return `DDC_FIR_CTRL;
      endcase
   endfunction

   function automatic logic isWord(input logic [7:0] addr);
      return addr == `DDC_FIR_COEFF_0 || addr == `DDC_FIR_COEFF_1 ||
             addr == `DDC_FIR_COEFF_2 || addr == `DDC_FIR_COEFF_3;
   endfunction

   function automatic logic [31:0] mergeLanes(input logic [31:0] old,
                                              input logic [31:0] data,
                                              input logic [3:0]  strb);
      logic [31:0] merged;
      merged = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            merged[8*b +: 8] = data[8*b +: 8];
         end
      end
      return merged;
   endfunction

   function automatic logic [31:0] expectedRead(input logic [7:0] addr);
      logic [31:0] data;
      data = '0;
      if (addr == `DDC_FIR_CTRL) begin
         data[0] = shadowEnable;
      end else if (isWord(addr)) begin
         data = shadowWord[addr[3:2]];
      end
      return data;
   endfunction

   // symmetric sum over the history, floor shift by 15, clip to 16 bits
   function automatic logic [15:0] firModel();
      longint      c [8];
      longint      acc;
      longint      scaled;
      logic [15:0] result;
      for (int w = 0; w < 4; w++) begin
         c[2*w]   = longint'($signed(shadowWord[w][15:0]));
         c[2*w+1] = longint'($signed(shadowWord[w][31:16]));
      end
      acc = hist[7] * c[7];
      for (int k = 0; k < 7; k++) begin
         acc += (hist[k] + hist[NumTaps-1-k]) * c[k];
      end
      scaled = acc >>> 15;
      if (scaled > 32767) begin
         clipHi++;
         result = 16'h7FFF;
      end else if (scaled < -32768) begin
         clipLo++;
         result = 16'h8000;
      end else begin
         result = scaled[15:0];
      end
      return result;
   endfunction

   // one in four values at full scale
   function automatic logic [15:0] randFullScale();
      int          r;
      logic [15:0] value;
      r = $random(seed);
      case (r[2:0])
         3'd0: value = 16'h7FFF;
         3'd1: value = 16'h8000;
         default: value = r[31:16];
      endcase
      return value;
   endfunction

   task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic err);
      paddr   = addr;
      pwrite  = 1'b1;
      pwdata  = data;
      pstrb   = strb;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      assert (pready)
         else begin
            errors++;
            $display("%s: wait state in the APB write access cycle", testName);
         end
      while (!pready) begin
         @(negedge clk);
      end
      err = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pstrb   = 4'h0;
   endtask

   task automatic apbRead(input logic [7:0] addr, input logic [3:0] strb,
                          output logic [31:0] data, output logic err);
      paddr   = addr;
      pwrite  = 1'b0;
      pstrb   = strb;
      psel    = 1'b1;
      penable = 1'b0;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      assert (pready)
         else begin
            errors++;
            $display("%s: wait state in the APB read access cycle", testName);
         end
      while (!pready) begin
         @(negedge clk);
      end
      data = prdata;
      err  = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic checkedWrite(input logic [7:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
      logic err;
      logic expErr;
      expErr = !(isWord(addr) || addr == `DDC_FIR_CTRL);
      apbWrite(addr, data, strb, err);
      assert (err == expErr)
         else begin
            errors++;
            $display("Mismatch %s pslverr on write to %h: expected %0b, actual %0b",
                     testName, addr, expErr, err);
         end
      if (isWord(addr)) begin
         shadowWord[addr[3:2]] = mergeLanes(shadowWord[addr[3:2]], data, strb);
      end else if (addr == `DDC_FIR_CTRL && strb[0]) begin
         shadowEnable = data[0];
      end
   endtask

   task automatic checkedRead(input logic [7:0] addr);
      logic [31:0] data;
      logic        err;
      logic        expErr;
      expErr = !(isWord(addr) || addr == `DDC_FIR_CTRL);
      apbRead(addr, 4'h0, data, err);
      assert (data == expectedRead(addr))
         else begin
            errors++;
            $display("Mismatch %s read %h: expected %h, actual %h",
                     testName, addr, expectedRead(addr), data);
         end
      assert (err == expErr)
         else begin
            errors++;
            $display("Mismatch %s pslverr on read of %h: expected %0b, actual %0b",
                     testName, addr, expErr, err);
         end
   endtask

   // one sample for one cycle, the model only sees accepted ones
   task automatic sendSample(input logic [15:0] value);
      sampleIn    = value;
      sampleValid = 1'b1;
      if (shadowEnable) begin
         for (int i = NumTaps - 1; i > 0; i--) begin
            hist[i] = hist[i-1];
         end
         hist[0] = longint'($signed(value));
         expQ.push_back(firModel());
         dueQ.push_back(cycles + Latency);
      end
      @(posedge clk);
      #1;
      sampleValid = 1'b0;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic drain();
      while (dueQ.size() > 0) begin
         @(posedge clk);
         #1;
      end
      idle(2);
   endtask

   task automatic startTest(input string name);
      testName     = name;
      testErrStart = errors;
   endtask

   task automatic endTest();
      testsRun++;
      if (errors != testErrStart) begin
         testsFailed++;
         $display("test %s: failed with %0d errors", testName, errors - testErrStart);
      end else begin
         $display("test %s: ok", testName);
      end
   endtask

   initial begin : mainSeq
      logic [31:0] word;
      int          gap;
      clk          = 1'b0;
      rst          = 1'b1;
      paddr        = '0;
      psel         = 1'b0;
      penable      = 1'b0;
      pwrite       = 1'b0;
      pwdata       = '0;
      pstrb        = '0;
      sampleIn     = '0;
      sampleValid  = 1'b0;
      seed         = 5;
      cycles       = 0;
      errors       = 0;
      testsRun     = 0;
      testsFailed  = 0;
      clipHi       = 0;
      clipLo       = 0;
      shadowEnable = 1'b0;
      for (int w = 0; w < 4; w++) begin
         shadowWord[w] = '0;
      end
      for (int i = 0; i < NumTaps; i++) begin
         hist[i] = 0;
      end
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;

      startTest("register readback");
      for (int i = 0; i < 5; i++) begin
         checkedWrite(regAddr(i), $random(seed), 4'hF);
         checkedRead(regAddr(i));
      end
      for (int i = 0; i < 5; i++) begin
         for (int b = 0; b < 4; b++) begin
            checkedWrite(regAddr(i), $random(seed), 4'(1 << b));
            checkedRead(regAddr(i));
         end
      end
      endTest();

      startTest("unmapped access");
      checkedWrite(8'h14, 32'hFFFF_FFFF, 4'hF);
      checkedRead(8'h14);
      for (int i = 0; i < 5; i++) begin
         checkedRead(regAddr(i));
      end
      endTest();

      // c0..c6 ramp up, c7 is the largest
      startTest("impulse response");
      checkedWrite(`DDC_FIR_COEFF_0, 32'h0400_0200, 4'hF);
      checkedWrite(`DDC_FIR_COEFF_1, 32'h0800_0600, 4'hF);
      checkedWrite(`DDC_FIR_COEFF_2, 32'h0C00_0A00, 4'hF);
      checkedWrite(`DDC_FIR_COEFF_3, 32'h4000_0E00, 4'hF);
      checkedWrite(`DDC_FIR_CTRL, 32'h1, 4'hF);
      repeat (15) sendSample(16'h0000);
      sendSample(16'h7FFF);
      repeat (14) sendSample(16'h0000);
      drain();
      endTest();

      startTest("latency and throughput");
      for (int n = 0; n < 40; n++) begin
         sendSample(16'($random(seed)));
         gap = $random(seed) & 3;
         // alternate back-to-back bursts with gapped ones
         if (n % 8 < 4) begin
            gap = 0;
         end
         idle(gap);
      end
      drain();
      endTest();

      startTest("enable gating");
      checkedWrite(`DDC_FIR_CTRL, 32'h0, 4'hF);
      for (int n = 0; n < 6; n++) begin
         sendSample(16'($random(seed)));
         idle(1);
      end
      idle(6);
      checkedWrite(`DDC_FIR_CTRL, 32'h1, 4'hF);
      for (int n = 0; n < 20; n++) begin
         sendSample(16'($random(seed)));
      end
      drain();
      endTest();

      startTest("random stream with saturation");
      clipHi = 0;
      clipLo = 0;
      for (int blk = 0; blk < 4; blk++) begin
         for (int w = 0; w < 4; w++) begin
            // block 2 runs every tap at full gain so the sum clips both ways
            if (blk == 2) begin
               word = 32'h7FFF_7FFF;
            end else begin
               word = {randFullScale(), randFullScale()};
            end
            checkedWrite(regAddr(w), word, 4'hF);
         end
         for (int n = 0; n < 50; n++) begin
            sendSample(randFullScale());
            if (($random(seed) & 15) == 0) begin
               idle(1);
            end
         end
      end
      drain();
      assert (clipHi > 0 && clipLo > 0)
         else begin
            errors++;
            $display("%s: the stream never reached both clipping limits", testName);
         end
      endTest();

      idle(4);
      $display("%0d tests run, %0d failed, %0d errors", testsRun, testsFailed, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule
